//--- include/tcdm_fsm_cfg.svh
// #####################################################################
// TCDM burst exerciser configuration
// Port count, burst length and bus widths shared by the whole design
// #####################################################################

`ifndef TCDM_FSM_CFG_SVH
`define TCDM_FSM_CFG_SVH

// number of burst engines, one TCDM master port each
`define TCDM_NUM_PORTS 4

// reads per burst, keep it a power of two
`define TCDM_BURST_LEN 16

`define TCDM_ADDR_W 20  // byte address
`define TCDM_DATA_W 32

`define APB_ADDR_W 7  // word index, byte address / 4
`define APB_DATA_W 20

`define GPIO_W 4  // pads

`endif

//--- source/tcdm_fsm_pkg.sv
// #####################################################################
// TCDM burst exerciser types
// Bus word types, beat counter type and the APB register map
// #####################################################################

`include "tcdm_fsm_cfg.svh"

package tcdm_fsm_pkg;

  typedef logic [`TCDM_ADDR_W-1:0] tcdm_addr_t;
  typedef logic [`TCDM_DATA_W-1:0] tcdm_data_t;

  typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [`APB_DATA_W-1:0] apb_data_t;

  // one spare msb, set once all beats have been granted
  typedef logic [$clog2(`TCDM_BURST_LEN):0] beat_cnt_t;

  // register word indices
  typedef enum logic [`APB_ADDR_W-1:0] {
    REG_START_0     = 'h00,  // write base address, starts engine 0
    REG_START_1     = 'h01,
    REG_START_2     = 'h02,
    REG_START_3     = 'h03,
    REG_STATUS      = 'h04,  // done vector
    REG_BURST_CNT   = 'h05,  // completed bursts, mod 256
    REG_GPIO_VAL    = 'h10,
    REG_GPIO_OE     = 'h20,
    REG_GPIO_SAMPLE = 'h21   // pads -> value register
  } reg_idx_e;

endpackage

//--- source/tcdm_master_if.sv
// #####################################################################
// TCDM read master port
// Request side driven by a burst engine, grant and valid returned
// #####################################################################

interface tcdm_master_if
  import tcdm_fsm_pkg::*;
();

  logic       req;
  tcdm_addr_t addr;
  tcdm_data_t wdata;
  logic       gnt;
  logic       r_valid;  // one cycle after gnt

  modport master(
    output req,
    output addr,
    output wdata,
    input  gnt,
    input  r_valid
  );

  modport slave(
    input  req,
    input  addr,
    input  wdata,
    output gnt,
    output r_valid
  );

endinterface

//--- source/apb_reg_decode.sv
// #####################################################################
// APB register block
// Decodes access-phase writes into engine start pulses, holds the
// GPIO value and output-enable registers and muxes readback data
// #####################################################################

`include "tcdm_fsm_cfg.svh"

module apb_reg_decode
  import tcdm_fsm_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  apb_addr_t                  paddr_i,
  input  apb_data_t                  pwdata_i,
  output apb_data_t                  prdata_o,

  output logic [`TCDM_NUM_PORTS-1:0] start_o,
  output tcdm_addr_t                 base_addr_o,  // shared by all engines

  input  logic [`TCDM_NUM_PORTS-1:0] done_vec_i,
  input  logic [7:0]                 burst_cnt_i,

  input  logic [`GPIO_W-1:0]         gpio_in_i,
  output logic [`GPIO_W-1:0]         gpio_oe_o,
  output logic [`GPIO_W-1:0]         gpio_val_o
);

  logic wr_en;
  logic rd_en;

  logic [`GPIO_W-1:0] gpio_oe_q;
  logic [`GPIO_W-1:0] gpio_val_q;

  // no wait states, so the access cycle is the only one that counts
  assign wr_en = psel_i & penable_i & pwrite_i;
  assign rd_en = psel_i & penable_i & ~pwrite_i;

  assign base_addr_o = tcdm_addr_t'(pwdata_i);

  // start registers sit at consecutive word indices
  always_comb begin
    start_o = '0;
    for (int i = 0; i < `TCDM_NUM_PORTS; i++) begin
      if (wr_en && (paddr_i == apb_addr_t'(REG_START_0 + i))) begin
        start_o[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gpio_oe_q  <= '0;
      gpio_val_q <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        REG_GPIO_VAL: begin
          gpio_val_q <= pwdata_i[`GPIO_W-1:0];
        end
        REG_GPIO_OE: begin
          gpio_oe_q <= pwdata_i[`GPIO_W-1:0];
        end
        REG_GPIO_SAMPLE: begin
          gpio_val_q <= gpio_in_i;  // data is ignored, pads are latched
        end
        default: begin
        end
      endcase
    end
  end

  assign gpio_oe_o  = gpio_oe_q;
  assign gpio_val_o = gpio_val_q;

  // readback, zero outside a read access and for unmapped indices
  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      case (paddr_i)
        REG_STATUS: begin
          prdata_o[`TCDM_NUM_PORTS-1:0] = done_vec_i;
        end
        REG_BURST_CNT: begin
          prdata_o[7:0] = burst_cnt_i;
        end
        REG_GPIO_VAL: begin
          prdata_o[`GPIO_W-1:0] = gpio_val_q;
        end
        REG_GPIO_OE: begin
          prdata_o[`GPIO_W-1:0] = gpio_oe_q;
        end
        default: begin
          prdata_o = '0;
        end
      endcase
    end
  end

endmodule

//--- source/tcdm_burst_fsm.sv
// #####################################################################
// TCDM burst read engine
// Issues one burst of word reads from a latched base address and
// reports done once the last response has come back
// #####################################################################

module tcdm_burst_fsm
  import tcdm_fsm_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 start_i,
  input  tcdm_addr_t           base_addr_i,

  tcdm_master_if.master        tcdm,

  output logic                 done_o,
  output logic                 burst_end_o
);

  localparam int unsigned CNT_W = $bits(beat_cnt_t);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } state_e;

  state_e     state_d, state_q;
  beat_cnt_t  cnt_q;
  tcdm_addr_t base_q;
  logic       accept_start;
  logic       incr;
  logic       last_beat;
  logic       done_q;

  assign accept_start = (state_q == IDLE) & start_i;  // busy engines drop starts
  assign last_beat    = cnt_q[CNT_W-1];                // all beats granted

  always_comb begin
    state_d     = state_q;
    tcdm.req    = 1'b0;
    incr        = 1'b0;
    burst_end_o = 1'b0;

    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = WAIT_GNT;
        end
      end

      WAIT_GNT: begin
        tcdm.req = 1'b1;  // held until granted
        if (tcdm.gnt) begin
          incr    = 1'b1;
          state_d = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (tcdm.r_valid) begin
          if (last_beat) begin
            burst_end_o = 1'b1;
            state_d     = IDLE;
          end else begin
            // next beat goes out in the same cycle as this response
            tcdm.req = 1'b1;
            if (tcdm.gnt) begin
              incr = 1'b1;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      if (burst_end_o) begin
        cnt_q  <= '0;  // drops the last-beat flag too
        done_q <= 1'b1;
      end else begin
        if (incr) begin
          cnt_q <= cnt_q + 1'b1;
        end
        if (accept_start) begin
          done_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_start) begin
      base_q <= base_addr_i;
    end
  end

  assign tcdm.addr  = base_q + tcdm_addr_t'({cnt_q, 2'b00});  // word stride
  assign tcdm.wdata = tcdm_data_t'(cnt_q[CNT_W-2:0]);          // beat index
  assign done_o     = done_q;

endmodule

//--- source/burst_status_collect.sv
// #####################################################################
// Burst status collector
// Registers the engines' done levels and counts finished bursts
// #####################################################################

`include "tcdm_fsm_cfg.svh"

module burst_status_collect (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic [`TCDM_NUM_PORTS-1:0] done_i,
  input  logic [`TCDM_NUM_PORTS-1:0] burst_end_i,

  output logic [`TCDM_NUM_PORTS-1:0] done_vec_o,
  output logic [7:0]                 burst_cnt_o
);

  logic [`TCDM_NUM_PORTS-1:0] done_vec_q;
  logic [7:0]                 burst_cnt_q;
  logic [7:0]                 end_sum;

  // several engines may finish in the same cycle
  always_comb begin
    end_sum = '0;
    for (int i = 0; i < `TCDM_NUM_PORTS; i++) begin
      end_sum = end_sum + 8'(burst_end_i[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_vec_q  <= '1;  // engines come out of reset idle
      burst_cnt_q <= '0;
    end else begin
      done_vec_q  <= done_i;
      burst_cnt_q <= burst_cnt_q + end_sum;  // wraps at 256
    end
  end

  assign done_vec_o  = done_vec_q;
  assign burst_cnt_o = burst_cnt_q;

endmodule

//--- source/tcdm_fsm_gpio_top.sv
// #####################################################################
// TCDM read-burst exerciser with GPIO
// APB register block, one burst engine per TCDM port and a status
// collector, all behind flat pad-level ports
// #####################################################################

`include "tcdm_fsm_cfg.svh"

module tcdm_fsm_gpio_top
  import tcdm_fsm_pkg::*;
(
  input  logic                                          clk_i,
  input  logic                                          rst_ni,

  input  logic                                          apb_psel_i,
  input  logic                                          apb_penable_i,
  input  logic                                          apb_pwrite_i,
  input  apb_addr_t                                     apb_addr_i,
  input  apb_data_t                                     apb_pwdata_i,
  output apb_data_t                                     apb_prdata_o,
  output logic                                          apb_ready_o,

  output logic [`TCDM_NUM_PORTS-1:0]                    tcdm_req_o,
  output logic [`TCDM_NUM_PORTS*`TCDM_ADDR_W-1:0]       tcdm_addr_o,
  output logic [`TCDM_NUM_PORTS-1:0]                    tcdm_wen_o,
  output logic [`TCDM_NUM_PORTS*`TCDM_DATA_W-1:0]       tcdm_wdata_o,
  output logic [`TCDM_NUM_PORTS*(`TCDM_DATA_W/8)-1:0]   tcdm_be_o,
  input  logic [`TCDM_NUM_PORTS-1:0]                    tcdm_gnt_i,
  input  logic [`TCDM_NUM_PORTS-1:0]                    tcdm_r_valid_i,

  output logic [`GPIO_W-1:0]                            gpio_oe_o,
  output logic [`GPIO_W-1:0]                            gpio_data_o,
  input  logic [`GPIO_W-1:0]                            gpio_data_i
);

  localparam int unsigned AW = `TCDM_ADDR_W;
  localparam int unsigned DW = `TCDM_DATA_W;

  logic [`TCDM_NUM_PORTS-1:0] start;
  tcdm_addr_t                 base_addr;
  logic [`TCDM_NUM_PORTS-1:0] done;
  logic [`TCDM_NUM_PORTS-1:0] burst_end;
  logic [`TCDM_NUM_PORTS-1:0] done_vec;
  logic [7:0]                 burst_cnt;

  tcdm_master_if tcdm_if [`TCDM_NUM_PORTS] ();

  // read-only master, no wait states on APB
  assign apb_ready_o = 1'b1;
  assign tcdm_wen_o  = '1;  // high means read
  assign tcdm_be_o   = '1;

  apb_reg_decode u_reg_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .psel_i      (apb_psel_i),
    .penable_i   (apb_penable_i),
    .pwrite_i    (apb_pwrite_i),
    .paddr_i     (apb_addr_i),
    .pwdata_i    (apb_pwdata_i),
    .prdata_o    (apb_prdata_o),
    .start_o     (start),
    .base_addr_o (base_addr),
    .done_vec_i  (done_vec),
    .burst_cnt_i (burst_cnt),
    .gpio_in_i   (gpio_data_i),
    .gpio_oe_o   (gpio_oe_o),
    .gpio_val_o  (gpio_data_o)
  );

  for (genvar i = 0; i < `TCDM_NUM_PORTS; i++) begin : g_engine
    tcdm_burst_fsm u_burst_fsm (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .start_i     (start[i]),
      .base_addr_i (base_addr),
      .tcdm        (tcdm_if[i]),
      .done_o      (done[i]),
      .burst_end_o (burst_end[i])
    );

    // port i owns slice i of each flat vector
    assign tcdm_req_o[i]             = tcdm_if[i].req;
    assign tcdm_addr_o[i*AW +: AW]   = tcdm_if[i].addr;
    assign tcdm_wdata_o[i*DW +: DW]  = tcdm_if[i].wdata;
    assign tcdm_if[i].gnt            = tcdm_gnt_i[i];
    assign tcdm_if[i].r_valid        = tcdm_r_valid_i[i];
  end

  burst_status_collect u_status (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .done_i      (done),
    .burst_end_i (burst_end),
    .done_vec_o  (done_vec),
    .burst_cnt_o (burst_cnt)
  );

endmodule

//--- testbench/tcdm_mem_model.sv
// #####################################################################
// TCDM slave responder for one master port
// Grants after a random delay, returns r_valid one cycle after each
// grant and logs the granted address and wdata for checking
// #####################################################################

module tcdm_mem_model
  import tcdm_fsm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       hold_i,       // blocks every grant while high
  input  logic [1:0] max_delay_i,  // upper bound of the grant delay
  input  logic       req_i,
  input  tcdm_addr_t addr_i,
  input  tcdm_data_t wdata_i,
  output logic       gnt_o,
  output logic       r_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  tcdm_addr_t addr_log[$];
  tcdm_data_t wdata_log[$];

  logic [1:0] wait_q    = 2'd0;  // cycles left before the next grant
  logic [1:0] wait_next = 2'd0;
  logic       accepted  = 1'b0;

  initial r_valid_o = 1'b0;

  assign gnt_o = req_i & ~hold_i & (wait_q == 2'd0);

  // handshake is judged at the rising edge
  always @(posedge clk_i) begin
    accepted  = req_i & gnt_o;
    wait_next = wait_q;
    if (accepted) begin
      addr_log.push_back(addr_i);
      wdata_log.push_back(wdata_i);
      wait_next = 2'($urandom_range(max_delay_i, 0));  // delay for the next request
    end else if (req_i && (wait_q != 2'd0)) begin
      wait_next = wait_q - 2'd1;
    end
  end

  // responses change on the falling edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      r_valid_o <= 1'b0;
      wait_q    <= 2'd0;
    end else begin
      r_valid_o <= accepted;  // one response per accepted request
      wait_q    <= wait_next;
    end
  end

endmodule

//--- testbench/tb_tcdm_fsm_top.sv
// #####################################################################
// Testbench for the TCDM read-burst exerciser
// Programs bursts over APB, answers every TCDM port with a memory
// model and checks each granted beat, the status and the GPIO block
// #####################################################################

`include "tcdm_fsm_cfg.svh"

module tb_tcdm_fsm_top
  import tcdm_fsm_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NP         = `TCDM_NUM_PORTS;
  localparam int unsigned AW         = `TCDM_ADDR_W;
  localparam int unsigned DW         = `TCDM_DATA_W;
  localparam int unsigned BLEN       = `TCDM_BURST_LEN;
  localparam int unsigned NUM_BURSTS = 10;   // bursts started over all tests
  localparam int unsigned MAX_POLLS  = 100;
  localparam apb_data_t   ALL_DONE   = apb_data_t'((1 << NP) - 1);

  logic clk_i = 1'b0;
  logic rst_ni;

  logic psel, penable, pwrite, pready;
  apb_addr_t paddr;
  apb_data_t pwdata, prdata;

  logic [NP-1:0]        tcdm_req, tcdm_wen;
  logic [NP*AW-1:0]     tcdm_addr;
  logic [NP*DW-1:0]     tcdm_wdata;
  logic [NP*DW/8-1:0]   tcdm_be;
  wire  [NP-1:0]        tcdm_gnt, tcdm_r_valid;
  logic [`GPIO_W-1:0]   gpio_oe, gpio_out, gpio_in;

  logic       mem_hold;
  logic [1:0] mem_max_delay;

  tcdm_addr_t  exp_base [NP];   // base of the burst each port should run
  int unsigned beat_seen [NP];
  logic        busy [NP];
  int unsigned bursts_started;

  always #20 clk_i = ~clk_i;

  tcdm_fsm_gpio_top dut0 (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .apb_psel_i (psel), .apb_penable_i (penable), .apb_pwrite_i (pwrite),
    .apb_addr_i (paddr), .apb_pwdata_i (pwdata), .apb_prdata_o (prdata),
    .apb_ready_o (pready),
    .tcdm_req_o (tcdm_req), .tcdm_addr_o (tcdm_addr), .tcdm_wen_o (tcdm_wen),
    .tcdm_wdata_o (tcdm_wdata), .tcdm_be_o (tcdm_be),
    .tcdm_gnt_i (tcdm_gnt), .tcdm_r_valid_i (tcdm_r_valid),
    .gpio_oe_o (gpio_oe), .gpio_data_o (gpio_out), .gpio_data_i (gpio_in)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    abort_run($sformatf("mismatch at %0t ns: %s", $time, what));
  endtask

  // beat k of a burst reads base + 4k and carries k on wdata
  function automatic void expected_beat(input tcdm_addr_t base, input int unsigned k,
                                        output tcdm_addr_t addr, output tcdm_data_t wdata);
    addr  = base + tcdm_addr_t'(4 * k);
    wdata = tcdm_data_t'(k);
  endfunction

  for (genvar p = 0; p < NP; p++) begin : g_port
    tcdm_mem_model u_mem (
      .clk_i (clk_i), .rst_ni (rst_ni), .hold_i (mem_hold), .max_delay_i (mem_max_delay),
      .req_i (tcdm_req[p]), .addr_i (tcdm_addr[p*AW +: AW]),
      .wdata_i (tcdm_wdata[p*DW +: DW]), .gnt_o (tcdm_gnt[p]), .r_valid_o (tcdm_r_valid[p])
    );

    always @(negedge clk_i) begin : compare_beats
      tcdm_addr_t got_addr, exp_addr;
      tcdm_data_t got_wdata, exp_wdata;
      while (u_mem.addr_log.size() > 0) begin
        got_addr  = u_mem.addr_log.pop_front();
        got_wdata = u_mem.wdata_log.pop_front();
        assert (beat_seen[p] < BLEN) else
          report_mismatch($sformatf("port %0d granted more than %0d reads", p, BLEN));
        expected_beat(exp_base[p], beat_seen[p], exp_addr, exp_wdata);
        assert (got_addr == exp_addr) else
          report_mismatch($sformatf("port %0d beat %0d addr 0x%0h, expected 0x%0h",
                                    p, beat_seen[p], got_addr, exp_addr));
        assert (got_wdata == exp_wdata) else
          report_mismatch($sformatf("port %0d beat %0d wdata 0x%0h, expected 0x%0h",
                                    p, beat_seen[p], got_wdata, exp_wdata));
        assert (tcdm_wen[p] && (&tcdm_be[p*DW/8 +: DW/8])) else
          report_mismatch($sformatf("port %0d wen or be not tied for reads", p));
        beat_seen[p]++;
      end
    end
  end

  task automatic apb_write(input apb_addr_t idx, input apb_data_t data);
    @(negedge clk_i);
    psel    = 1'b1;  // setup cycle
    pwrite  = 1'b1;
    paddr   = idx;
    pwdata  = data;
    @(negedge clk_i);
    penable = 1'b1;  // access cycle, takes effect on the next rising edge
    @(negedge clk_i);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t idx, output apb_data_t data);
    @(negedge clk_i);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = idx;
    @(negedge clk_i);
    penable = 1'b1;
    #10 data = prdata;  // middle of the access cycle
    @(negedge clk_i);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_reg(input apb_addr_t idx, input apb_data_t exp, input string name);
    apb_data_t got;
    apb_read(idx, got);
    assert (got === exp) else
      report_mismatch($sformatf("%s read 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // only a start to an idle engine opens a new burst
  task automatic start_port(input int unsigned p, input tcdm_addr_t base);
    if (!busy[p]) begin
      exp_base[p]  = base;
      beat_seen[p] = 0;
      busy[p]      = 1'b1;
      bursts_started++;
    end
    apb_write(apb_addr_t'(REG_START_0) + apb_addr_t'(p), apb_data_t'(base));
  endtask

  task automatic wait_done(input int unsigned p);
    apb_data_t   status;
    int unsigned polls;
    status = '0;
    polls  = 0;
    while (!status[p]) begin
      if (polls == MAX_POLLS) begin
        abort_run($sformatf("port %0d never reported done in %0d status reads", p, polls));
      end
      apb_read(REG_STATUS, status);
      polls++;
    end
    assert (beat_seen[p] == BLEN) else
      report_mismatch($sformatf("port %0d saw %0d reads, expected %0d", p, beat_seen[p], BLEN));
    busy[p] = 1'b0;
  endtask

  function automatic tcdm_addr_t random_base();
    return tcdm_addr_t'($urandom) & ~tcdm_addr_t'(3);  // word aligned
  endfunction

  initial begin : watchdog
    repeat (200 * NUM_BURSTS + 2000) @(posedge clk_i);
    abort_run("watchdog expired, the DUT stopped making progress");
  end

  initial begin : stimulus
    apb_data_t status;
    void'($urandom(32'ha4d8_3745));
    rst_ni = 1'b0;
    {psel, penable, pwrite} = '0;
    paddr = '0;
    pwdata = '0;
    gpio_in = '0;
    mem_hold = 1'b0;
    mem_max_delay = 2'd3;
    bursts_started = 0;
    for (int i = 0; i < NP; i++) begin
      exp_base[i]  = '0;
      beat_seen[i] = 0;
      busy[i]      = 1'b0;
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    // state out of reset
    @(negedge clk_i);
    assert ((tcdm_req == '0) && (gpio_oe == '0) && (gpio_out == '0) && pready) else
      report_mismatch("req, GPIO or pready wrong after reset");
    check_reg(REG_STATUS, ALL_DONE, "status after reset");
    check_reg(REG_BURST_CNT, '0, "burst count after reset");

    // single burst on port 0
    start_port(0, random_base());
    apb_read(REG_STATUS, status);
    assert (!status[0]) else report_mismatch("status bit 0 set during a burst");
    wait_done(0);

    // all ports at once with random grant delays
    for (int unsigned p = 0; p < NP; p++) start_port(p, random_base());
    for (int unsigned p = 0; p < NP; p++) wait_done(p);
    check_reg(REG_STATUS, ALL_DONE, "status after parallel bursts");
    check_reg(REG_BURST_CNT, apb_data_t'(8'(bursts_started)), "burst count");

    // grants held back, then all engines run in lockstep and end together
    @(negedge clk_i);
    mem_hold = 1'b1;
    mem_max_delay = 2'd0;
    for (int unsigned p = 0; p < NP; p++) start_port(p, random_base());
    repeat (4) @(negedge clk_i);
    mem_hold = 1'b0;
    for (int unsigned p = 0; p < NP; p++) wait_done(p);
    check_reg(REG_BURST_CNT, apb_data_t'(8'(bursts_started)), "burst count, joint ends");

    // second start to a busy engine is dropped
    @(negedge clk_i);
    mem_max_delay = 2'd3;
    start_port(1, random_base());
    start_port(1, random_base());
    wait_done(1);
    repeat (20) @(negedge clk_i);  // room for reads of a wrongly taken start
    check_reg(REG_BURST_CNT, apb_data_t'(8'(bursts_started)), "burst count at end");

    // GPIO registers and pad sampling
    apb_write(REG_GPIO_VAL, apb_data_t'(4'ha));
    apb_write(REG_GPIO_OE, apb_data_t'(4'h5));
    check_reg(REG_GPIO_VAL, apb_data_t'(4'ha), "GPIO value");
    check_reg(REG_GPIO_OE, apb_data_t'(4'h5), "GPIO enable");
    assert ((gpio_out == 4'ha) && (gpio_oe == 4'h5)) else
      report_mismatch("GPIO pads do not follow the registers");
    @(negedge clk_i);
    gpio_in = 4'h6;
    apb_write(REG_GPIO_SAMPLE, '0);
    assert (gpio_out == 4'h6) else report_mismatch("sampled pads not on gpio_data_o");
    check_reg(REG_GPIO_VAL, apb_data_t'(4'h6), "GPIO value after sample");

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
source/tcdm_fsm_pkg.sv
source/tcdm_master_if.sv
source/apb_reg_decode.sv
source/tcdm_burst_fsm.sv
source/burst_status_collect.sv
source/tcdm_fsm_gpio_top.sv
testbench/tcdm_mem_model.sv
testbench/tb_tcdm_fsm_top.sv
